// ==== sim.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/alu_exec.sv
rtl/result_fifo.sv
rtl/cdb_arbiter.sv
rtl/cdb_writeback_top.sv
bench/tb_cdb_writeback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module tb_cdb_writeback \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== bench/tb_cdb_writeback.sv ====
`include "wb_params.svh"

module tb_cdb_writeback import wb_pkg::*; ();

    // test lengths in operations per lane
    localparam int DIR_OPS   = 20;
    localparam int RAND_OPS  = 60;
    localparam int SAT_OPS   = 50;
    localparam int FLUSH_OPS = 40;
    localparam int POST_OPS  = 20;
    localparam int TOTAL_OPS = `WB_FU_COUNT * (DIR_OPS * 1 + RAND_OPS + SAT_OPS
                                               + FLUSH_OPS + POST_OPS);
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 1000;
    localparam int DRAIN_LIMIT     = 100;
    localparam int FLUSH_CYCLE     = 15;   // cycle of the flush pulse in its test
    localparam int ALL_READY       = (1 << `WB_FU_COUNT) - 1;

    logic clk;
    logic arst_n_i;
    logic flush_i;

    logic    [`WB_FU_COUNT-1:0]                   issue_valid_i;
    logic    [`WB_FU_COUNT-1:0]                   issue_ready_o;
    alu_op_t [`WB_FU_COUNT-1:0]                   issue_op_i;
    logic    [`WB_FU_COUNT-1:0][`WB_DATA_W-1:0]   issue_src0_i;
    logic    [`WB_FU_COUNT-1:0][`WB_DATA_W-1:0]   issue_src1_i;
    logic    [`WB_FU_COUNT-1:0][`WB_ROB_ID_W-1:0] issue_rob_id_i;
    logic    [`WB_FU_COUNT-1:0]                   issue_w_reg_i;

    logic [`WB_CDB_COUNT-1:0]                   cdb_valid_o;
    logic [`WB_CDB_COUNT-1:0][`WB_ROB_ID_W-1:0] cdb_rob_id_o;
    logic [`WB_CDB_COUNT-1:0][`WB_DATA_W-1:0]   cdb_data_o;
    logic [`WB_CDB_COUNT-1:0]                   cdb_w_reg_o;

    cdb_info_t               exp_q [`WB_FU_COUNT][$]; // expected results per lane
    int                      acc_q [`WB_FU_COUNT][$]; // acceptance cycle per result
    logic [`WB_ROB_ID_W-3:0] seq [`WB_FU_COUNT];
    logic [31:0]             lfsr_state = 32'he36a8de4;
    string                   test_name = "reset";
    bit                      latency_check = 1'b0;
    int                      cycle_cnt = 0;
    int                      stall_cycles = 0;
    int                      issued_total = 0;
    int                      received_total = 0;
    int                      value_errors = 0;
    int                      protocol_errors = 0;

    cdb_writeback_top dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ready_o  (issue_ready_o),
        .issue_op_i     (issue_op_i),
        .issue_src0_i   (issue_src0_i),
        .issue_src1_i   (issue_src1_i),
        .issue_rob_id_i (issue_rob_id_i),
        .issue_w_reg_i  (issue_w_reg_i),
        .cdb_valid_o    (cdb_valid_o),
        .cdb_rob_id_o   (cdb_rob_id_o),
        .cdb_data_o     (cdb_data_o),
        .cdb_w_reg_o    (cdb_w_reg_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr stepping one bit per call
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // expected alu result straight from the operation definitions
    function automatic logic [`WB_DATA_W-1:0] alu_ref(input alu_op_t op,
                                                      input logic [`WB_DATA_W-1:0] a,
                                                      input logic [`WB_DATA_W-1:0] b);
        logic [4:0]            sh;
        logic [`WB_DATA_W-1:0] r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            // signs differ, so the negative one is smaller
            ALU_SLT:  r = (a[`WB_DATA_W-1] != b[`WB_DATA_W-1]) ? `WB_DATA_W'(a[`WB_DATA_W-1])
                                                                : `WB_DATA_W'(a < b);
            ALU_SLTU: r = `WB_DATA_W'(a < b);
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[`WB_DATA_W-1] ? ~({`WB_DATA_W{1'b1}} >> sh) : '0);
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int l = 0; l < `WB_FU_COUNT; l++) begin
            n += exp_q[l].size();
        end
        return n;
    endfunction

    task automatic check_result(input string name, input cdb_info_t exp, input cdb_info_t act);
        if (exp !== act) begin
            value_errors++;
            $display("error %s: expected rob %h data %h w_reg %b, actual rob %h data %h w_reg %b",
                     name, exp.rob_id, exp.w_data, exp.w_reg, act.rob_id, act.w_data, act.w_reg);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errors++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_port(input int p);
        cdb_info_t act;
        cdb_info_t exp;
        int        lane;
        int        lat;
        act.rob_id = cdb_rob_id_o[p];
        act.w_data = cdb_data_o[p];
        act.w_reg  = cdb_w_reg_o[p];
        lane = int'(act.rob_id[`WB_ROB_ID_W-1 -: 2]); // lane sits in the top bits
        if (exp_q[lane].size() == 0) begin
            protocol_errors++;
            $display("%s: port %0d broadcast rob id %h but lane %0d has nothing outstanding",
                     test_name, p, act.rob_id, lane);
        end else begin
            exp = exp_q[lane].pop_front();
            lat = cycle_cnt - acc_q[lane].pop_front();
            check_result(test_name, exp, act);
            if (latency_check) begin
                check_count({test_name, " latency"}, 3, lat);
            end
            received_total++;
        end
    endtask

    task automatic check_ports();
        if (cdb_valid_o[1] && !cdb_valid_o[0]) begin
            protocol_errors++;
            $display("%s: cdb port 1 valid while port 0 is idle", test_name);
        end
        if (&cdb_valid_o && (cdb_rob_id_o[0][`WB_ROB_ID_W-1 -: 2] ==
                             cdb_rob_id_o[1][`WB_ROB_ID_W-1 -: 2])) begin
            protocol_errors++;
            $display("%s: both cdb ports carry results of one lane", test_name);
        end
        for (int p = 0; p < `WB_CDB_COUNT; p++) begin
            if (cdb_valid_o[p]) begin
                compare_port(p);
            end
        end
    endtask

    task automatic record_issue(input int l);
        cdb_info_t exp;
        exp.rob_id = issue_rob_id_i[l];
        exp.w_data = alu_ref(issue_op_i[l], issue_src0_i[l], issue_src1_i[l]);
        exp.w_reg  = issue_w_reg_i[l];
        exp_q[l].push_back(exp);
        acc_q[l].push_back(cycle_cnt);
        issued_total++;
    endtask

    // scoreboard sampled on every rising edge
    always @(posedge clk) begin
        if (arst_n_i) begin
            cycle_cnt++;
            check_ports();
            for (int l = 0; l < `WB_FU_COUNT; l++) begin
                if (issue_valid_i[l] && !issue_ready_o[l]) begin
                    stall_cycles++;
                end
                if (flush_i) begin
                    issued_total -= exp_q[l].size(); // flushed results never return
                    exp_q[l].delete();
                    acc_q[l].delete();
                end else if (issue_valid_i[l] && issue_ready_o[l]) begin
                    record_issue(l);
                end
            end
        end
    end

    task automatic load_op(input int l, input bit directed, input int k);
        alu_op_t op;
        if (directed) begin
            op = alu_op_t'(4'(k % 10)); // walk through every op
        end else begin
            op = alu_op_t'(4'(rand_bits(4) % 10));
        end
        issue_op_i[l]     <= op;
        issue_src0_i[l]   <= rand_bits(32);
        issue_src1_i[l]   <= rand_bits(32);
        issue_w_reg_i[l]  <= lfsr_bit();
        issue_rob_id_i[l] <= {2'(l), seq[l]};
        issue_valid_i[l]  <= 1'b1;
        seq[l] = seq[l] + 1'b1;
    endtask

    task automatic run_traffic(input string name, input logic [`WB_FU_COUNT-1:0] mask,
                               input int n_ops, input bit every_cycle, input bit directed,
                               input int flush_at);
        int to_offer [`WB_FU_COUNT];
        int cyc;
        bit busy;
        bit pending;
        test_name = name;
        for (int l = 0; l < `WB_FU_COUNT; l++) begin
            to_offer[l] = mask[l] ? n_ops : 0;
        end
        cyc  = 0;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            flush_i <= (cyc == flush_at);
            busy = 1'b0;
            for (int l = 0; l < `WB_FU_COUNT; l++) begin
                pending = issue_valid_i[l] && !issue_ready_o[l];
                if (pending) begin
                    busy = 1'b1; // hold the offer until taken
                end else if (to_offer[l] > 0 && (every_cycle || lfsr_bit())) begin
                    load_op(l, directed, n_ops - to_offer[l]);
                    to_offer[l]--;
                    busy = 1'b1;
                end else begin
                    issue_valid_i[l] <= 1'b0;
                    if (to_offer[l] > 0) begin
                        busy = 1'b1;
                    end
                end
            end
            cyc++;
        end
    endtask

    task automatic wait_drain();
        int guard;
        guard = 0;
        while (outstanding() != 0 && guard < DRAIN_LIMIT) begin
            @(posedge clk);
            guard++;
        end
        repeat (5) @(posedge clk); // room for a stray duplicate
        for (int l = 0; l < `WB_FU_COUNT; l++) begin
            check_count($sformatf("%s lane %0d results missing", test_name, l),
                        0, exp_q[l].size());
            exp_q[l].delete();
            acc_q[l].delete();
        end
    endtask

    initial begin
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        issue_valid_i  = '0;
        issue_op_i     = {`WB_FU_COUNT{ALU_ADD}};
        issue_src0_i   = '0;
        issue_src1_i   = '0;
        issue_rob_id_i = '0;
        issue_w_reg_i  = '0;
        for (int l = 0; l < `WB_FU_COUNT; l++) begin
            seq[l] = '0;
        end
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        check_count("ready after reset", ALL_READY, int'(issue_ready_o));
        repeat (10) @(posedge clk); // cdb must stay quiet

        // one lane at a time so port 0 is uncontended
        latency_check = 1'b1;
        for (int l = 0; l < `WB_FU_COUNT; l++) begin
            run_traffic($sformatf("directed lane %0d", l), `WB_FU_COUNT'(1 << l),
                        DIR_OPS, 1'b1, 1'b1, -1);
            wait_drain();
        end
        latency_check = 1'b0;

        run_traffic("random", '1, RAND_OPS, 1'b0, 1'b0, -1);
        wait_drain();

        stall_cycles = 0;
        run_traffic("saturation", '1, SAT_OPS, 1'b1, 1'b0, -1);
        if (stall_cycles == 0) begin
            protocol_errors++;
            $display("saturation: issue_ready_o never dropped with all lanes busy");
        end
        wait_drain();
        check_count("ready after saturation", ALL_READY, int'(issue_ready_o));

        run_traffic("flush", '1, FLUSH_OPS, 1'b0, 1'b0, FLUSH_CYCLE);
        wait_drain();
        check_count("ready after flush", ALL_READY, int'(issue_ready_o));

        run_traffic("after flush", '1, POST_OPS, 1'b1, 1'b0, -1);
        wait_drain();
        check_count("results received", issued_total, received_total);

        $display("errors: value %0d, protocol %0d; results checked %0d",
                 value_errors, protocol_errors, received_total);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s, traffic did not complete",
                 WATCHDOG_CYCLES, test_name);
        $display("errors: value %0d, protocol %0d; results checked %0d",
                 value_errors, protocol_errors, received_total);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== rtl/cdb_writeback_top.sv ====
`include "wb_params.svh"

module cdb_writeback_top import wb_pkg::*; (
    input  logic                                            clk,
    input  logic                                            arst_n_i,
    input  logic                                            flush_i,

    // issue lanes
    input  logic    [`WB_FU_COUNT-1:0]                      issue_valid_i,
    output logic    [`WB_FU_COUNT-1:0]                      issue_ready_o,
    input  alu_op_t [`WB_FU_COUNT-1:0]                      issue_op_i,
    input  logic    [`WB_FU_COUNT-1:0][`WB_DATA_W-1:0]      issue_src0_i,
    input  logic    [`WB_FU_COUNT-1:0][`WB_DATA_W-1:0]      issue_src1_i,
    input  logic    [`WB_FU_COUNT-1:0][`WB_ROB_ID_W-1:0]    issue_rob_id_i,
    input  logic    [`WB_FU_COUNT-1:0]                      issue_w_reg_i,

    // cdb broadcast
    output logic    [`WB_CDB_COUNT-1:0]                     cdb_valid_o,
    output logic    [`WB_CDB_COUNT-1:0][`WB_ROB_ID_W-1:0]   cdb_rob_id_o,
    output logic    [`WB_CDB_COUNT-1:0][`WB_DATA_W-1:0]     cdb_data_o,
    output logic    [`WB_CDB_COUNT-1:0]                     cdb_w_reg_o
);

    // execute unit to fifo
    logic      [`WB_FU_COUNT-1:0] res_valid;
    logic      [`WB_FU_COUNT-1:0] res_ready;
    cdb_info_t [`WB_FU_COUNT-1:0] res_info;

    // fifo heads to arbiter
    logic      [`WB_FU_COUNT-1:0] head_valid;
    cdb_info_t [`WB_FU_COUNT-1:0] head_info;
    logic      [`WB_FU_COUNT-1:0] head_pop;

    for (genvar g = 0; g < `WB_FU_COUNT; g++) begin : g_lane

        alu_exec u_alu_exec (
            .clk            (clk),
            .arst_n_i       (arst_n_i),
            .flush_i        (flush_i),
            .issue_valid_i  (issue_valid_i[g]),
            .issue_ready_o  (issue_ready_o[g]),
            .issue_op_i     (issue_op_i[g]),
            .issue_src0_i   (issue_src0_i[g]),
            .issue_src1_i   (issue_src1_i[g]),
            .issue_rob_id_i (issue_rob_id_i[g]),
            .issue_w_reg_i  (issue_w_reg_i[g]),
            .res_valid_o    (res_valid[g]),
            .res_ready_i    (res_ready[g]),
            .res_o          (res_info[g])
        );

        // registered head so a push shows up one cycle later
        result_fifo #(
            .DEPTH (`WB_FIFO_DEPTH)
        ) u_result_fifo (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .flush_i      (flush_i),
            .push_valid_i (res_valid[g]),
            .push_ready_o (res_ready[g]),
            .push_data_i  (res_info[g]),
            .head_valid_o (head_valid[g]),
            .head_o       (head_info[g]),
            .pop_i        (head_pop[g])
        );

    end

    cdb_arbiter u_cdb_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .head_valid_i (head_valid),
        .head_i       (head_info),
        .pop_o        (head_pop),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_rob_id_o (cdb_rob_id_o),
        .cdb_data_o   (cdb_data_o),
        .cdb_w_reg_o  (cdb_w_reg_o)
    );

endmodule

// ==== rtl/cdb_arbiter.sv ====
`include "wb_params.svh"

module cdb_arbiter import wb_pkg::*; (
    input  logic                                       clk,
    input  logic                                       arst_n_i,
    input  logic                                       flush_i,

    input  logic      [`WB_FU_COUNT-1:0]               head_valid_i,
    input  cdb_info_t [`WB_FU_COUNT-1:0]               head_i,
    output logic      [`WB_FU_COUNT-1:0]               pop_o,

    output logic      [`WB_CDB_COUNT-1:0]              cdb_valid_o,
    output logic      [`WB_CDB_COUNT-1:0][`WB_ROB_ID_W-1:0] cdb_rob_id_o,
    output logic      [`WB_CDB_COUNT-1:0][`WB_DATA_W-1:0]   cdb_data_o,
    output logic      [`WB_CDB_COUNT-1:0]              cdb_w_reg_o
);

    localparam int LANE_W = $clog2(`WB_FU_COUNT);

    logic [LANE_W-1:0]                     rr_q;      // lane scanned first
    logic [LANE_W-1:0]                     rr_next;
    logic [LANE_W-1:0]                     idx;
    logic [LANE_W-1:0]                     last_lane;
    logic [`WB_CDB_COUNT-1:0]              sel_valid;
    logic [`WB_CDB_COUNT-1:0][LANE_W-1:0]  sel_lane;
    int                                    grant_cnt;

    // scan from rr_q and take the first two valid heads
    always_comb begin
        pop_o     = '0;
        sel_valid = '0;
        sel_lane  = '0;
        idx       = '0;
        last_lane = rr_q;
        grant_cnt = 0;
        for (int i = 0; i < `WB_FU_COUNT; i++) begin
            idx = LANE_W'((int'(rr_q) + i) % `WB_FU_COUNT);
            if (head_valid_i[idx] && (grant_cnt < `WB_CDB_COUNT)) begin
                pop_o[idx]           = 1'b1;
                sel_valid[grant_cnt] = 1'b1; // first grant lands on port 0
                sel_lane[grant_cnt]  = idx;
                last_lane            = idx;
                grant_cnt            = grant_cnt + 1;
            end
        end
    end

    // move past the last winner and hold when idle
    assign rr_next = (|pop_o) ? LANE_W'((int'(last_lane) + 1) % `WB_FU_COUNT) : rr_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q        <= '0;
            cdb_valid_o <= '0;
        end else if (flush_i) begin
            rr_q        <= '0;
            cdb_valid_o <= '0;
        end else begin
            rr_q        <= rr_next;
            cdb_valid_o <= sel_valid;
        end
    end

    // broadcast payload qualified by cdb_valid_o
    always_ff @(posedge clk) begin
        for (int p = 0; p < `WB_CDB_COUNT; p++) begin
            cdb_rob_id_o[p] <= head_i[sel_lane[p]].rob_id;
            cdb_data_o[p]   <= head_i[sel_lane[p]].w_data;
            cdb_w_reg_o[p]  <= head_i[sel_lane[p]].w_reg;
        end
    end

    // two grants in one cycle come from two lanes
    grant_unique_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        sel_valid[1] |-> (sel_lane[0] != sel_lane[1]));

    // port 1 only carries a result alongside port 0
    port_order_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        cdb_valid_o[1] |-> cdb_valid_o[0]);

endmodule

// ==== rtl/result_fifo.sv ====
`include "wb_params.svh"

module result_fifo import wb_pkg::*; #(
    parameter int DEPTH = `WB_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      flush_i,

    input  logic      push_valid_i,
    output logic      push_ready_o,
    input  cdb_info_t push_data_i,

    output logic      head_valid_o,
    output cdb_info_t head_o,
    input  logic      pop_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cdb_info_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_fire;

    // wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign push_ready_o = (count_q != CNT_W'(DEPTH)); // no bypass when full
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign push_fire    = push_valid_i && push_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_fire, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // arbiter only pops a visible head
    pop_not_empty_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        pop_i |-> head_valid_o);

    // full and not draining means nothing gets written
    no_push_full_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        !push_ready_o && !pop_i && !flush_i |=> !push_ready_o && $stable(wr_ptr_q));

endmodule

// ==== rtl/alu_exec.sv ====
`include "wb_params.svh"

module alu_exec import wb_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,

    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  alu_op_t                 issue_op_i,
    input  logic [`WB_DATA_W-1:0]   issue_src0_i,
    input  logic [`WB_DATA_W-1:0]   issue_src1_i,
    input  logic [`WB_ROB_ID_W-1:0] issue_rob_id_i,
    input  logic                    issue_w_reg_i,

    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output cdb_info_t               res_o
);

    logic [`WB_DATA_W-1:0] alu_result;
    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic                  issue_fire;

    assign shamt       = issue_src1_i[4:0];
    assign lt_signed   = $signed(issue_src0_i) < $signed(issue_src1_i);
    assign lt_unsigned = issue_src0_i < issue_src1_i;

    // output reg empty or drained this cycle
    assign issue_ready_o = !res_valid_o || res_ready_i;
    assign issue_fire    = issue_valid_i && issue_ready_o;

    always_comb begin
        case (issue_op_i)
            ALU_ADD:  alu_result = issue_src0_i + issue_src1_i;
            ALU_SUB:  alu_result = issue_src0_i - issue_src1_i;
            ALU_AND:  alu_result = issue_src0_i & issue_src1_i;
            ALU_OR:   alu_result = issue_src0_i | issue_src1_i;
            ALU_XOR:  alu_result = issue_src0_i ^ issue_src1_i;
            ALU_SLT:  alu_result = {{(`WB_DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_result = {{(`WB_DATA_W-1){1'b0}}, lt_unsigned};
            ALU_SLL:  alu_result = issue_src0_i << shamt;
            ALU_SRL:  alu_result = issue_src0_i >> shamt;
            ALU_SRA:  alu_result = $signed(issue_src0_i) >>> shamt;
            default:  alu_result = '0; // unused encodings
        endcase
    end

    // valid bit of the output register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0; // drops same-cycle issue too
        end else if (issue_ready_o) begin
            res_valid_o <= issue_valid_i;
        end
    end

    // payload only moves on acceptance
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_o.rob_id <= issue_rob_id_i;
            res_o.w_data <= alu_result;
            res_o.w_reg  <= issue_w_reg_i;
        end
    end

    // a stalled result must hold until the fifo takes it
    res_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid_o && !res_ready_i && !flush_i |=> res_valid_o && $stable(res_o));

endmodule

// ==== rtl/wb_pkg.sv ====
`include "wb_params.svh"

package wb_pkg;

    // integer alu operations
    // shift amount is the low 5 bits of src1
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5, // signed compare
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    // tagged result as stored in the fifos and sent on the cdb
    typedef struct packed {
        logic [`WB_ROB_ID_W-1:0] rob_id;
        logic [`WB_DATA_W-1:0]   w_data;
        logic                    w_reg;  // result targets a register
    } cdb_info_t;

endpackage

// ==== rtl/wb_params.svh ====
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// issue lanes and matching result fifos
`define WB_FU_COUNT 4

// broadcast ports on the cdb
`define WB_CDB_COUNT 2

// operand and result width
`define WB_DATA_W 32

// destination tag (rob id)
`define WB_ROB_ID_W 6

// entries per result fifo
`define WB_FIFO_DEPTH 2

`endif
